//--- logic/mem_msg_pkg.sv
/*
  memory message definitions: field widths, type codes and bank geometry
*/

package mem_msg_pkg;

  // ==========================================================================
  // memory request / response fields
  // ==========================================================================

  // request and response share one type code
  typedef enum logic [1:0] {
    mem_read   = 2'd0,
    mem_write  = 2'd1,
    mem_dirmem = 2'd2
  } mem_type_t;

  // top bits of opaque carry the source core id while in flight
  localparam int mem_opaque_nbits = 8;
  localparam int mem_addr_nbits   = 32;
  localparam int mem_data_nbits   = 32;
  // len is always zero here, single word
  localparam int mem_len_nbits    = 2;

  // ==========================================================================
  // bank geometry
  // ==========================================================================

  localparam int bank_nwords     = 16;
  // words from this index up need the secure domain
  localparam int secure_word_lsb = 8;

endpackage

//--- logic/net_msg_pkg.sv
/*
  network message definitions: source/dest fields and the control word,
  which is read either as a request header or as a response header
*/

package net_msg_pkg;

  import mem_msg_pkg::*;

  // two ports on each side
  localparam int net_srcdest_nbits = 1;

  // request view, as built by the request adapter
  typedef struct packed {
    logic [net_srcdest_nbits-1:0] dest;
    logic [net_srcdest_nbits-1:0] src;
    // 1 is the secure domain
    logic                         domain;
    logic                         spare;
    mem_type_t                    msg_type;
    logic [mem_opaque_nbits-1:0]  opaque;
    logic [mem_addr_nbits-1:0]    addr;
    logic [mem_len_nbits-1:0]     len;
  } net_req_hdr_t;

  // response view, no address so the tail is padding
  typedef struct packed {
    logic [net_srcdest_nbits-1:0] dest;
    logic [net_srcdest_nbits-1:0] src;
    logic                         domain;
    logic                         fail;
    mem_type_t                    msg_type;
    logic [mem_opaque_nbits-1:0]  opaque;
    logic [mem_len_nbits-1:0]     len;
    logic [mem_addr_nbits-1:0]    pad;
  } net_resp_hdr_t;

  // dest sits in the top bits in both views
  typedef union packed {
    net_req_hdr_t  req;
    net_resp_hdr_t resp;
  } net_ctrl_u;

  localparam int net_ctrl_nbits = $bits(net_ctrl_u);

endpackage

//--- logic/mem_req_to_net.sv
/*
  memory request to network adapter: picks the bank, tags opaque with
  the core id and packs the request header
*/

`timescale 1ns/1ps

module mem_req_to_net
  import mem_msg_pkg::*, net_msg_pkg::*;
#(
  parameter int net_src     = 0,
  parameter int single_bank = 0
) (
  // 0 instruction, 1 data
  input  logic                        mode,
  input  logic                        domain,
  input  mem_type_t                   msg_type,
  input  logic [mem_opaque_nbits-1:0] opaque,
  input  logic [mem_addr_nbits-1:0]   addr,
  input  logic [mem_len_nbits-1:0]    len,
  input  logic [mem_data_nbits-1:0]   data,
  output net_ctrl_u                   net_ctrl,
  output logic [mem_data_nbits-1:0]   net_data
);

  // bank split points for each mode
  localparam logic [mem_addr_nbits-1:0] inst_split = 32'h0000_4000;
  localparam logic [mem_addr_nbits-1:0] data_split = 32'h0000_c000;
  localparam int                        low_nbits  = mem_opaque_nbits - net_srcdest_nbits;

  logic [net_srcdest_nbits-1:0] dest;

  // dirmem first, then single bank, then the per-mode split
  always_comb begin
    if (msg_type == mem_dirmem) begin
      dest = net_srcdest_nbits'(1);
    end else if (single_bank != 0) begin
      dest = '0;
    end else if (mode) begin
      dest = (addr < data_split) ? net_srcdest_nbits'(0) : net_srcdest_nbits'(1);
    end else begin
      dest = (addr < inst_split) ? net_srcdest_nbits'(0) : net_srcdest_nbits'(1);
    end
  end

  always_comb begin
    net_ctrl              = '0;
    net_ctrl.req.dest     = dest;
    net_ctrl.req.src      = net_srcdest_nbits'(net_src);
    net_ctrl.req.domain   = domain;
    net_ctrl.req.spare    = 1'b0;
    net_ctrl.req.msg_type = msg_type;
    // high opaque bits now name the core so the response finds its way back
    net_ctrl.req.opaque   = {net_srcdest_nbits'(net_src), opaque[low_nbits-1:0]};
    net_ctrl.req.addr     = addr;
    net_ctrl.req.len      = len;
  end

  assign net_data = data;

endmodule

//--- logic/mem_resp_to_net.sv
/*
  memory response to network adapter: routes on the opaque high bits
  and packs the response header
*/

`timescale 1ns/1ps

module mem_resp_to_net
  import mem_msg_pkg::*, net_msg_pkg::*;
#(
  parameter int net_src = 0
) (
  input  mem_type_t                   msg_type,
  input  logic [mem_opaque_nbits-1:0] opaque,
  input  logic [mem_len_nbits-1:0]    len,
  input  logic [mem_data_nbits-1:0]   data,
  input  logic                        domain,
  input  logic                        fail,
  output net_ctrl_u                   net_ctrl,
  output logic [mem_data_nbits-1:0]   net_data
);

  localparam int low_nbits = mem_opaque_nbits - net_srcdest_nbits;

  always_comb begin
    net_ctrl               = '0;
    // core id was placed here by the request adapter
    net_ctrl.resp.dest     = opaque[mem_opaque_nbits-1 -: net_srcdest_nbits];
    net_ctrl.resp.src      = net_srcdest_nbits'(net_src);
    net_ctrl.resp.domain   = domain;
    net_ctrl.resp.fail     = fail;
    net_ctrl.resp.msg_type = msg_type;
    // clear the routing tag before it reaches the core
    net_ctrl.resp.opaque   = {{net_srcdest_nbits{1'b0}}, opaque[low_nbits-1:0]};
    net_ctrl.resp.len      = len;
    net_ctrl.resp.pad      = '0;
  end

  assign net_data = data;

endmodule

//--- logic/net_xbar.sv
/*
  2x2 network crossbar with credit buffered inputs, round-robin arbitration
  per output and a downstream credit count per output
*/

`timescale 1ns/1ps

module net_xbar
  import mem_msg_pkg::*, net_msg_pkg::*;
#(
  parameter int buf_depth = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_val     [2],
  input  net_ctrl_u                 in_ctrl    [2],
  input  logic [mem_data_nbits-1:0] in_data    [2],
  output logic                      in_credit  [2],
  output logic                      out_val    [2],
  output net_ctrl_u                 out_ctrl   [2],
  output logic [mem_data_nbits-1:0] out_data   [2],
  input  logic                      out_credit [2]
);

  localparam int ptr_nbits = (buf_depth > 1) ? $clog2(buf_depth) : 1;
  localparam int cnt_nbits = $clog2(buf_depth + 1);

  // input buffers, one FIFO per crossbar input
  net_ctrl_u                 fifo_ctrl [2][buf_depth];
  logic [mem_data_nbits-1:0] fifo_data [2][buf_depth];
  logic [ptr_nbits-1:0]      wr_ptr    [2];
  logic [ptr_nbits-1:0]      rd_ptr    [2];
  logic [cnt_nbits-1:0]      fill      [2];
  net_ctrl_u                 head_ctrl [2];
  logic [mem_data_nbits-1:0] head_data [2];

  // per output credit count and round-robin state
  // rr names the input that wins a tie
  logic [cnt_nbits-1:0]      credit    [2];
  logic                      rr        [2];
  logic                      sel       [2];
  logic [1:0]                cand      [2];

  function automatic logic [ptr_nbits-1:0] next_ptr(input logic [ptr_nbits-1:0] p);
    return (p == ptr_nbits'(buf_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // ==========================================================================
  // arbitration and output mux
  // ==========================================================================

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      head_ctrl[i] = fifo_ctrl[i][rd_ptr[i]];
      head_data[i] = fifo_data[i][rd_ptr[i]];
    end
    for (int o = 0; o < 2; o++) begin
      // dest sits at the same place in both views so the req view serves both
      for (int i = 0; i < 2; i++) begin
        cand[o][i] = (fill[i] != '0) && (head_ctrl[i].req.dest == net_srcdest_nbits'(o));
      end
      sel[o]      = cand[o][rr[o]] ? rr[o] : ~rr[o];
      out_val[o]  = (cand[o] != 2'b00) && (credit[o] != '0);
      out_ctrl[o] = head_ctrl[sel[o]];
      out_data[o] = head_data[sel[o]];
    end
    // a head leaves on the cycle its output fires and its slot credit goes back
    for (int i = 0; i < 2; i++) begin
      in_credit[i] = (out_val[0] && (sel[0] == 1'(i))) || (out_val[1] && (sel[1] == 1'(i)));
    end
  end

  // ==========================================================================
  // buffer pointers, credit counters, round-robin state
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        fill[i]   <= '0;
        credit[i] <= cnt_nbits'(buf_depth);
        rr[i]     <= 1'b0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (in_val[i]) begin
          wr_ptr[i] <= next_ptr(wr_ptr[i]);
        end
        if (in_credit[i]) begin
          rd_ptr[i] <= next_ptr(rd_ptr[i]);
        end
        if (in_val[i] && !in_credit[i]) begin
          fill[i] <= fill[i] + 1'b1;
        end else if (!in_val[i] && in_credit[i]) begin
          fill[i] <= fill[i] - 1'b1;
        end
      end
      for (int o = 0; o < 2; o++) begin
        if (out_val[o] && !out_credit[o]) begin
          credit[o] <= credit[o] - 1'b1;
        end else if (!out_val[o] && out_credit[o]) begin
          credit[o] <= credit[o] + 1'b1;
        end
        // loser of this round gets priority next time
        if (out_val[o]) begin
          rr[o] <= ~sel[o];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (in_val[i]) begin
        fifo_ctrl[i][wr_ptr[i]] <= in_ctrl[i];
        fifo_data[i][wr_ptr[i]] <= in_data[i];
      end
    end
  end

  for (genvar k = 0; k < 2; k++) begin : g_chk
    // upstream credit keeps the buffer from overflowing
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      in_val[k] |-> fill[k] != cnt_nbits'(buf_depth));
    // downstream never hands back more credit than it was given
    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
      out_credit[k] && !out_val[k] |-> credit[k] != cnt_nbits'(buf_depth));
  end

endmodule

//--- logic/mem_bank.sv
/*
  16-word memory bank with secure-domain check and a one-entry
  response register sent under response credit
*/

`timescale 1ns/1ps

module mem_bank
  import mem_msg_pkg::*, net_msg_pkg::*;
#(
  parameter int bank_id   = 0,
  parameter int buf_depth = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_val,
  input  net_ctrl_u                   req_ctrl,
  input  logic [mem_data_nbits-1:0]   req_data,
  output logic                        req_credit,
  output logic                        resp_val,
  output mem_type_t                   resp_type,
  output logic [mem_opaque_nbits-1:0] resp_opaque,
  output logic [mem_len_nbits-1:0]    resp_len,
  output logic [mem_data_nbits-1:0]   resp_data,
  output logic                        resp_domain,
  output logic                        resp_fail,
  input  logic                        resp_credit
);

  localparam int idx_nbits = $clog2(bank_nwords);
  localparam int cnt_nbits = $clog2(buf_depth + 1);

  logic [mem_data_nbits-1:0] mem [bank_nwords];
  logic [idx_nbits-1:0]      idx;
  logic                      fail;
  logic                      full;
  // credits toward the response crossbar input
  logic [cnt_nbits-1:0]      credit;
  // upstream starts with buf_depth credits but there is one slot here,
  // so the first buf_depth-1 returns are kept back
  logic [cnt_nbits-1:0]      debt;

  // word index from addr[5:2]
  assign idx  = req_ctrl.req.addr[2 +: idx_nbits];
  // non-secure access to the upper half is refused
  assign fail = !req_ctrl.req.domain && (idx >= idx_nbits'(secure_word_lsb));

  assign resp_val   = full && (credit != '0);
  // request credit is returned only when the slot drains
  assign req_credit = resp_val && (debt == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full   <= 1'b0;
      credit <= cnt_nbits'(buf_depth);
      debt   <= cnt_nbits'(buf_depth - 1);
      for (int w = 0; w < bank_nwords; w++) begin
        mem[w] <= '0;
      end
    end else begin
      if (req_val) begin
        full <= 1'b1;
      end else if (resp_val) begin
        full <= 1'b0;
      end
      if (resp_val && !resp_credit) begin
        credit <= credit - 1'b1;
      end else if (!resp_val && resp_credit) begin
        credit <= credit + 1'b1;
      end
      if (resp_val && (debt != '0)) begin
        debt <= debt - 1'b1;
      end
      // failed writes leave the word untouched
      if (req_val && (req_ctrl.req.msg_type == mem_write) && !fail) begin
        mem[idx] <= req_data;
      end
    end
  end

  // response payload, dirmem reads like a plain read
  always_ff @(posedge clk) begin
    if (req_val) begin
      resp_type   <= req_ctrl.req.msg_type;
      resp_opaque <= req_ctrl.req.opaque;
      resp_len    <= req_ctrl.req.len;
      resp_domain <= req_ctrl.req.domain;
      resp_fail   <= fail;
      if (fail || (req_ctrl.req.msg_type == mem_write)) begin
        resp_data <= '0;
      end else begin
        resp_data <= mem[idx];
      end
    end
  end

  // the held-back credits keep a stalled slot from being overrun
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    req_val |-> !full || resp_val);
  // request crossbar only delivers traffic meant for this bank
  a_dest_match: assert property (@(posedge clk) disable iff (!rst_n)
    req_val |-> req_ctrl.req.dest == net_srcdest_nbits'(bank_id));

endmodule

//--- logic/mem_net_top.sv
/*
  two-core, two-bank memory interconnect: request adapters and crossbar,
  banks, response adapters and crossbar
*/

`timescale 1ns/1ps

module mem_net_top
  import mem_msg_pkg::*, net_msg_pkg::*;
#(
  parameter int single_bank = 0,
  parameter int buf_depth   = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // core request ports, index is the core id
  input  logic                        req_val     [2],
  input  mem_type_t                   req_type    [2],
  input  logic [mem_opaque_nbits-1:0] req_opaque  [2],
  input  logic [mem_addr_nbits-1:0]   req_addr    [2],
  input  logic [mem_len_nbits-1:0]    req_len     [2],
  input  logic [mem_data_nbits-1:0]   req_data    [2],
  input  logic                        req_mode    [2],
  input  logic                        req_domain  [2],
  output logic                        req_credit  [2],
  // core response ports
  output logic                        resp_val    [2],
  output mem_type_t                   resp_type   [2],
  output logic [mem_opaque_nbits-1:0] resp_opaque [2],
  output logic [mem_len_nbits-1:0]    resp_len    [2],
  output logic [mem_data_nbits-1:0]   resp_data   [2],
  output logic                        resp_domain [2],
  output logic                        resp_fail   [2],
  input  logic                        resp_credit [2]
);

  // request side links
  net_ctrl_u                 rq_ctrl    [2];
  logic [mem_data_nbits-1:0] rq_data    [2];
  logic                      bk_val     [2];
  net_ctrl_u                 bk_ctrl    [2];
  logic [mem_data_nbits-1:0] bk_data    [2];
  logic                      bk_credit  [2];
  // response side links
  logic                      rs_val     [2];
  net_ctrl_u                 rs_ctrl    [2];
  logic [mem_data_nbits-1:0] rs_data    [2];
  logic                      rs_credit  [2];
  net_ctrl_u                 core_ctrl  [2];

  net_xbar #(.buf_depth(buf_depth)) req_xbar (
    .clk, .rst_n,
    .in_val(req_val), .in_ctrl(rq_ctrl), .in_data(rq_data), .in_credit(req_credit),
    .out_val(bk_val), .out_ctrl(bk_ctrl), .out_data(bk_data), .out_credit(bk_credit)
  );

  net_xbar #(.buf_depth(buf_depth)) resp_xbar (
    .clk, .rst_n,
    .in_val(rs_val), .in_ctrl(rs_ctrl), .in_data(rs_data), .in_credit(rs_credit),
    .out_val(resp_val), .out_ctrl(core_ctrl), .out_data(resp_data), .out_credit(resp_credit)
  );

  // index i is core i on the request side and bank i on the response side
  for (genvar i = 0; i < 2; i++) begin : g_slice
    mem_type_t                   b_type;
    logic [mem_opaque_nbits-1:0] b_opaque;
    logic [mem_len_nbits-1:0]    b_len;
    logic [mem_data_nbits-1:0]   b_data;
    logic                        b_domain;
    logic                        b_fail;

    mem_req_to_net #(.net_src(i), .single_bank(single_bank)) u_req_adapt (
      .mode(req_mode[i]), .domain(req_domain[i]), .msg_type(req_type[i]),
      .opaque(req_opaque[i]), .addr(req_addr[i]), .len(req_len[i]), .data(req_data[i]),
      .net_ctrl(rq_ctrl[i]), .net_data(rq_data[i])
    );

    mem_bank #(.bank_id(i), .buf_depth(buf_depth)) u_bank (
      .clk, .rst_n,
      .req_val(bk_val[i]), .req_ctrl(bk_ctrl[i]), .req_data(bk_data[i]),
      .req_credit(bk_credit[i]),
      .resp_val(rs_val[i]), .resp_type(b_type), .resp_opaque(b_opaque), .resp_len(b_len),
      .resp_data(b_data), .resp_domain(b_domain), .resp_fail(b_fail),
      .resp_credit(rs_credit[i])
    );

    mem_resp_to_net #(.net_src(i)) u_resp_adapt (
      .msg_type(b_type), .opaque(b_opaque), .len(b_len), .data(b_data),
      .domain(b_domain), .fail(b_fail),
      .net_ctrl(rs_ctrl[i]), .net_data(rs_data[i])
    );

    // core side reads the response view
    assign resp_type[i]   = core_ctrl[i].resp.msg_type;
    assign resp_opaque[i] = core_ctrl[i].resp.opaque;
    assign resp_len[i]    = core_ctrl[i].resp.len;
    assign resp_domain[i] = core_ctrl[i].resp.domain;
    assign resp_fail[i]   = core_ctrl[i].resp.fail;
  end

endmodule

//--- bench/mem_net_model.svh
/*
  reference model: bank routing rule, shadow bank contents and the
  secure-domain rule, used to predict every response
*/

`ifndef mem_net_model_svh
`define mem_net_model_svh

// shadow copy of both banks, 16 words each
logic [31:0] shadow [2][16];

task automatic model_clear();
  for (int b = 0; b < 2; b++) begin
    for (int w = 0; w < 16; w++) begin
      shadow[b][w] = '0;
    end
  end
endtask

// bank that a request is routed to
function automatic int model_route(input logic mode, input mem_type_t t,
                                   input logic [31:0] addr, input int single);
  // dirmem always goes to bank 1, even in single-bank mode
  if (t == mem_dirmem) begin
    return 1;
  end
  if (single != 0) begin
    return 0;
  end
  // data mode splits at 0xc000, instruction mode at 0x4000
  if (mode) begin
    return (addr < 32'h0000_c000) ? 0 : 1;
  end
  return (addr < 32'h0000_4000) ? 0 : 1;
endfunction

// one access to the shadow, gives the expected data and fail bit
task automatic model_access(input int bank, input mem_type_t t, input logic domain,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic fail);
  int idx;
  idx   = int'(addr[5:2]);
  // words 8 to 15 need the secure domain
  fail  = !domain && (idx >= 8);
  rdata = '0;
  if (!fail) begin
    if (t == mem_write) begin
      shadow[bank][idx] = wdata;
    end else begin
      // read and dirmem both return the word
      rdata = shadow[bank][idx];
    end
  end
endtask

`endif

//--- bench/mem_net_tb.sv
/*
  testbench for the two-core memory interconnect with seeded random traffic,
  a shadow bank model and credit handling on both core ports
*/

`timescale 1ns/1ps

module mem_net_tb
  import mem_msg_pkg::*;
();

  localparam int depth = 2;

  logic        clk;
  logic        rst_n;
  logic        req_val     [2];
  mem_type_t   req_type    [2];
  logic [7:0]  req_opaque  [2];
  logic [31:0] req_addr    [2];
  logic [1:0]  req_len     [2];
  logic [31:0] req_data    [2];
  logic        req_mode    [2];
  logic        req_domain  [2];
  logic        req_credit  [2];
  logic        resp_val    [2];
  mem_type_t   resp_type   [2];
  logic [7:0]  resp_opaque [2];
  logic [1:0]  resp_len    [2];
  logic [31:0] resp_data   [2];
  logic        resp_domain [2];
  logic        resp_fail   [2];
  logic        resp_credit [2];

  // pending requests per core packed as {mode, domain, type, addr, data}
  logic [67:0] req_q0 [$];
  logic [67:0] req_q1 [$];

  // expected responses indexed by core and opaque tag
  bit          exp_pend   [2][128];
  mem_type_t   exp_type   [2][128];
  logic        exp_domain [2][128];
  logic        exp_fail   [2][128];
  logic [31:0] exp_data   [2][128];
  logic [7:0]  exp_opaque [2][128];

  // per core bookkeeping
  int          credits       [2];
  int          issued        [2];
  int          credit_pulses [2];
  int          outstanding   [2];
  int          resp_seen     [2];
  int          credit_ret    [2];
  int          owed          [2];
  bit [6:0]    next_tag      [2];

  int          checks;
  int          errors;
  int          tests;
  int          tests_failed;
  int          test_err0;
  int          test_chk0;
  int          cycle;
  int          issue_pct;
  int          hold_cnt;
  bit          flood;
  bit          withhold;
  int unsigned seed;

  `include "mem_net_model.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  mem_net_top #(.single_bank(0), .buf_depth(depth)) DUT (
    .clk, .rst_n,
    .req_val, .req_type, .req_opaque, .req_addr, .req_len, .req_data,
    .req_mode, .req_domain, .req_credit,
    .resp_val, .resp_type, .resp_opaque, .resp_len, .resp_data,
    .resp_domain, .resp_fail, .resp_credit
  );

  // ==========================================================================
  // helpers
  // ==========================================================================

  // bit 2 carries the core id so the two cores never share a word
  function automatic logic [31:0] core_addr(input int c, input logic [31:0] a);
    return {a[31:3], 1'(c), 2'b00};
  endfunction

  function automatic mem_type_t random_type();
    return mem_type_t'($urandom % 3);
  endfunction

  task automatic push_req(input int c, input logic mode, input logic domain,
                          input mem_type_t t, input logic [31:0] a, input logic [31:0] d);
    logic [67:0] e;
    e = {mode, domain, 2'(t), core_addr(c, a), d};
    if (c == 0) begin
      req_q0.push_back(e);
    end else begin
      req_q1.push_back(e);
    end
  endtask

  task automatic check_val(input int c, input string sig, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error core%0d %s: got %h expected %h", c, sig, got, exp);
    end
  endtask

  // model prediction is taken at issue in per-core order
  task automatic record_issue(input int c, input logic [67:0] e, input logic [7:0] op);
    int          bank;
    logic [31:0] rdata;
    logic        fail;
    logic [6:0]  tag;
    tag  = op[6:0];
    bank = model_route(e[67], mem_type_t'(e[65:64]), e[63:32], 0);
    model_access(bank, mem_type_t'(e[65:64]), e[66], e[63:32], e[31:0], rdata, fail);
    checks++;
    if (exp_pend[c][tag]) begin
      errors++;
      $display("core %0d reused opaque tag %h while it was still outstanding", c, tag);
    end
    exp_pend[c][tag]   = 1'b1;
    exp_type[c][tag]   = mem_type_t'(e[65:64]);
    exp_domain[c][tag] = e[66];
    exp_fail[c][tag]   = fail;
    exp_data[c][tag]   = rdata;
    exp_opaque[c][tag] = op;
    outstanding[c]++;
    issued[c]++;
    credits[c]--;
  endtask

  // one response at a core, matched to its request by the opaque tag
  task automatic score_response(input int c);
    logic [6:0] tag;
    tag = resp_opaque[c][6:0];
    resp_seen[c]++;
    owed[c]++;
    checks++;
    if (resp_seen[c] > depth + credit_ret[c]) begin
      errors++;
      $display("core %0d got more responses than the credits it returned", c);
    end
    checks++;
    if (!exp_pend[c][tag]) begin
      errors++;
      $display("core %0d got opaque %h, which is not outstanding there", c, resp_opaque[c]);
    end else begin
      exp_pend[c][tag] = 1'b0;
      outstanding[c]--;
      check_val(c, "resp_opaque", 32'(resp_opaque[c]), 32'(exp_opaque[c][tag]));
      check_val(c, "resp_type", 32'(resp_type[c]), 32'(exp_type[c][tag]));
      check_val(c, "resp_domain", 32'(resp_domain[c]), 32'(exp_domain[c][tag]));
      check_val(c, "resp_fail", 32'(resp_fail[c]), 32'(exp_fail[c][tag]));
      check_val(c, "resp_data", resp_data[c], exp_data[c][tag]);
      check_val(c, "resp_len", 32'(resp_len[c]), 32'h0);
    end
  endtask

  // wait until both queues are empty and every response is back
  task automatic drain();
    while (req_q0.size() != 0 || req_q1.size() != 0 ||
           outstanding[0] != 0 || outstanding[1] != 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
  endtask

  task automatic begin_test();
    test_err0 = errors;
    test_chk0 = checks;
  endtask

  task automatic finish_test(input string name);
    drain();
    tests++;
    if (errors != test_err0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d checks, %0d errors", tests, name,
             (errors == test_err0) ? "pass" : "FAIL", checks - test_chk0, errors - test_err0);
  endtask

  // ==========================================================================
  // core side credits, issue and response checks
  // ==========================================================================

  always @(posedge clk) begin
    logic [67:0] e;
    logic [7:0]  op;
    bit          ready;
    if (rst_n) begin
      // long stretches with no response credit while flooding
      if (flood) begin
        if (hold_cnt == 0) begin
          withhold = !withhold;
          hold_cnt = withhold ? 20 + int'($urandom % 20) : 4 + int'($urandom % 8);
        end else begin
          hold_cnt--;
        end
      end else begin
        withhold = 1'b0;
      end
      for (int c = 0; c < 2; c++) begin
        if (req_credit[c]) begin
          credits[c]++;
          credit_pulses[c]++;
        end
        if (resp_val[c]) begin
          score_response(c);
        end
        // response credit goes back after a random delay
        resp_credit[c] <= 1'b0;
        if (owed[c] > 0 && !withhold && (flood || ($urandom % 2 == 0))) begin
          resp_credit[c] <= 1'b1;
          owed[c]--;
          credit_ret[c]++;
        end
        req_val[c] <= 1'b0;
        ready = (c == 0) ? (req_q0.size() != 0) : (req_q1.size() != 0);
        // a request goes out only while the core holds a credit
        if (ready && credits[c] > 0 && int'($urandom % 100) < issue_pct) begin
          if (c == 0) begin
            e = req_q0.pop_front();
          end else begin
            e = req_q1.pop_front();
          end
          // high opaque bit stays zero so the DUT can hand it back unchanged
          op = {1'b0, next_tag[c]};
          record_issue(c, e, op);
          req_val[c]    <= 1'b1;
          req_mode[c]   <= e[67];
          req_domain[c] <= e[66];
          req_type[c]   <= mem_type_t'(e[65:64]);
          req_addr[c]   <= e[63:32];
          req_data[c]   <= e[31:0];
          req_len[c]    <= 2'd0;
          req_opaque[c] <= op;
          next_tag[c]   = next_tag[c] + 7'd1;
        end
      end
    end
  end

  // run limit grows with the requests issued so far
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > 40 * (issued[0] + issued[1]) + 200) begin
      $display("timeout after %0d cycles, %0d and %0d responses still outstanding",
               cycle, outstanding[0], outstanding[1]);
      $display("Something failed");
      $finish;
    end
  end

  // ==========================================================================
  // tests
  // ==========================================================================

  // write in one mode and read back in the other before a dirmem read of bank 1
  task automatic routing_sweep();
    logic [31:0] a;
    logic        m;
    begin_test();
    for (int n = 0; n < 16; n++) begin
      for (int c = 0; c < 2; c++) begin
        a = ((($urandom % 2) == 0) ? 32'h4000 : 32'hc000) - 32'h80 + ($urandom % 32'h100);
        m = 1'($urandom);
        push_req(c, m, 1'b1, mem_write, a, $urandom);
        push_req(c, !m, 1'b1, mem_read, a, $urandom);
        push_req(c, m, 1'b1, mem_dirmem, a, $urandom);
      end
    end
    finish_test("routing");
  endtask

  // secure writes and reads anywhere in the address space
  task automatic write_read_pairs();
    logic [31:0] a;
    logic        m;
    begin_test();
    for (int n = 0; n < 24; n++) begin
      for (int c = 0; c < 2; c++) begin
        a = $urandom;
        m = 1'($urandom);
        push_req(c, m, 1'b1, mem_write, a, $urandom);
        push_req(c, m, 1'b1, mem_read, a, $urandom);
      end
    end
    finish_test("write then read");
  endtask

  // secure words refuse non-secure access and keep their old value
  task automatic domain_protection();
    logic [31:0] a;
    int          idx;
    begin_test();
    for (int i = 0; i < 4; i++) begin
      for (int c = 0; c < 2; c++) begin
        idx = 8 + 2 * i + c;
        a   = ((i < 2) ? 32'h0 : 32'hc000) | 32'(idx << 2);
        push_req(c, 1'b1, 1'b1, mem_write, a, $urandom);
        push_req(c, 1'b1, 1'b0, mem_write, a, $urandom);
        push_req(c, 1'b1, 1'b0, mem_read, a, $urandom);
        push_req(c, 1'b1, 1'b1, mem_read, a, $urandom);
        // lower words stay open to the non-secure domain
        push_req(c, 1'b1, 1'b0, mem_write, a - 32'h20, $urandom);
        push_req(c, 1'b1, 1'b0, mem_read, a - 32'h20, $urandom);
      end
    end
    finish_test("domain protection");
  endtask

  // fully random mode, domain, type and address from both cores
  task automatic mixed_traffic();
    begin_test();
    for (int n = 0; n < 40; n++) begin
      for (int c = 0; c < 2; c++) begin
        push_req(c, 1'($urandom), 1'($urandom), random_type(), $urandom, $urandom);
      end
    end
    finish_test("response return");
  endtask

  // both cores flood bank 0 in data mode with response credit starved
  task automatic bank0_flood();
    int pulses0 [2];
    int acc0    [2];
    begin_test();
    for (int c = 0; c < 2; c++) begin
      pulses0[c] = credit_pulses[c];
      acc0[c]    = issued[c];
    end
    flood     = 1'b1;
    issue_pct = 100;
    for (int n = 0; n < 30; n++) begin
      for (int c = 0; c < 2; c++) begin
        push_req(c, 1'b1, 1'b1, mem_type_t'($urandom % 2), $urandom % 32'hc000, $urandom);
      end
    end
    drain();
    flood     = 1'b0;
    issue_pct = 70;
    // every accepted request frees exactly one buffer slot
    for (int c = 0; c < 2; c++) begin
      check_val(c, "req_credit pulses", 32'(credit_pulses[c] - pulses0[c]),
                32'(issued[c] - acc0[c]));
    end
    finish_test("back-pressure");
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    seed      = $urandom(32'hc564_ebdb);
    rst_n     = 1'b0;
    issue_pct = 70;
    for (int c = 0; c < 2; c++) begin
      req_val[c]     = 1'b0;
      req_type[c]    = mem_read;
      req_opaque[c]  = '0;
      req_addr[c]    = '0;
      req_len[c]     = '0;
      req_data[c]    = '0;
      req_mode[c]    = 1'b0;
      req_domain[c]  = 1'b0;
      resp_credit[c] = 1'b0;
      credits[c]     = depth;
    end
    model_clear();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // val and credit outputs come out of reset low
    begin_test();
    @(negedge clk);
    for (int c = 0; c < 2; c++) begin
      check_val(c, "req_credit", 32'(req_credit[c]), 32'h0);
      check_val(c, "resp_val", 32'(resp_val[c]), 32'h0);
    end
    finish_test("reset state");

    routing_sweep();
    write_read_pairs();
    domain_protection();
    mixed_traffic();
    bank0_flood();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- src.f
logic/mem_msg_pkg.sv
logic/net_msg_pkg.sv
logic/mem_req_to_net.sv
logic/mem_resp_to_net.sv
logic/net_xbar.sv
logic/mem_bank.sv
logic/mem_net_top.sv
+incdir+bench
bench/mem_net_tb.sv

//--- Makefile
# Verilator build and run of the memory interconnect testbench
TOP = mem_net_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
